// ==== trace_debugger.f ====
+incdir+common
common/trdb_rv_pkg.sv
common/trdb_pkg.sv
hw/trdb_delay_line.sv
hw/trdb_itype_detector.sv
hw/trdb_branch_map.sv
hw/trdb_priority.sv
hw/trdb_packet_emitter.sv
hw/trace_debugger.sv
verification/trdb_asserts.sv
verification/tb_trace_debugger.sv

// ==== Makefile ====
# trace_debugger simulation with Verilator

TOP := tb_trace_debugger

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f trace_debugger.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -qx "Verification passed" sim.log

lint:
	verilator --lint-only --timing --assert -f trace_debugger.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== verification/tb_trace_debugger.sv ====
/*
 * trace_debugger testbench
 * retires a program of nops, branches, jumps and traps, predicts each packet
 * from the encoder rules and checks every pulse against the prediction
 */
`timescale 1ns/1ps
`default_nettype none

`include "trdb_config.svh"

module tb_trace_debugger;

    import trdb_pkg::*;
    import trdb_rv_pkg::*;

    localparam int NUM_INST = 57;
    localparam int MAX_GAP  = 3;
    // four times the strobes plus their worst-case gaps
    localparam int TIMEOUT_CYCLES = 4 * NUM_INST * (MAX_GAP + 1);
    localparam int PL = `TRDB_PAYLOAD_LEN;
    localparam int LW = `TRDB_PLEN_LEN;
    localparam logic [31:0] NOP = 32'h0000_0013;

    typedef struct packed {
        trdb_format_e         ptype;
        trdb_sync_subformat_e sub;
        logic [LW-1:0]        len;
        logic [PL-1:0]        payload;
    } pkt_t;

    logic                         clk_i = 1'b0;
    logic                         rst_ni, inst_valid_i, exception_i, interrupt_i;
    logic                         trace_enable_i;
    logic [`TRDB_CAUSE_LEN-1:0]   cause_i;
    priv_lvl_e                    priv_lvl_i;
    logic [`TRDB_INST_LEN-1:0]    inst_data_i;
    logic [`TRDB_PC_LEN-1:0]      pc_i;
    logic                         packet_valid_o;
    trdb_format_e                 packet_type_o;
    trdb_sync_subformat_e         packet_subformat_o;
    logic [LW-1:0]                packet_length_o;
    logic [PL-1:0]                packet_payload_o;

    // reference model taps with nc at index 0, tc at 1 and lc at 2
    trdb_inst_rec_t               m_rec [3];
    logic [2:0]                   m_qual;
    int                           m_cnt;
    logic [`TRDB_BMAP_LEN-1:0]    m_map;
    pkt_t                         exp_q [$];
    pkt_t                         head;
    logic                         head_avail;
    // program state
    logic [`TRDB_PC_LEN-1:0]      pc_cur;
    priv_lvl_e                    cur_priv;
    logic [`TRDB_CAUSE_LEN-1:0]   cur_cause;
    logic                         cur_intr;
    int                           err_cnt, unexp_cnt, miss_cnt, cycle_cnt;

    trace_debugger DUT (.*);

    bind trace_debugger trdb_asserts u_asserts (
        .clk_i, .rst_ni, .inst_valid_i, .packet_valid_o,
        .packet_type_o, .packet_subformat_o, .packet_length_o
    );

    always #2 clk_i = ~clk_i;

    function automatic void refresh_head();
        head_avail = (exp_q.size() != 0);
        head       = '0;
        if (head_avail) begin
            head = exp_q[0];
        end
    endfunction

    function automatic int pick_gap();
        return $urandom % (MAX_GAP + 1);
    endfunction

    // first matching rule decides the new tc
    task automatic predict();
        trdb_inst_rec_t nc, tc, lc;
        logic           emit;
        pkt_t           p;
        nc = m_rec[0];
        tc = m_rec[1];
        lc = m_rec[2];
        if (m_qual[1]) begin
            // not-taken bit goes in at position count
            if (tc.inst[6:0] == OPCODE_BRANCH) begin
                m_map[m_cnt] = (nc.pc == tc.pc + 32'd4);
                m_cnt++;
            end
            emit = 1'b1;
            p    = '0;
            p.ptype = F3_SYNC;
            p.sub   = SF_START;
            if (m_qual[2] && lc.exception) begin
                p.sub = SF_TRAP;
            end else if (m_qual[2] && tc.priv == lc.priv) begin
                if (lc.inst[6:0] == OPCODE_JALR || !m_qual[0]) begin
                    p.ptype = (m_cnt == 0) ? F2_ADDR_ONLY : F1_BRANCH_MAP;
                end else if (m_cnt == `TRDB_BMAP_LEN) begin
                    p.ptype = F1_BRANCH_MAP;
                end else begin
                    emit = 1'b0;
                end
            end
            // payload fields LSB first
            case (p.ptype)
                F3_SYNC: begin
                    p.payload = PL'(p.sub) | (PL'(tc.priv) << 2);
                    if (p.sub == SF_TRAP) begin
                        p.payload = p.payload | (PL'(tc.cause) << 4)
                                    | (PL'(tc.interrupt) << 9) | (PL'(tc.pc) << 10);
                        p.len     = LW'(`TRDB_LEN_F3_TRAP);
                    end else begin
                        p.payload = p.payload | (PL'(tc.pc) << 4);
                        p.len     = LW'(`TRDB_LEN_F3_START);
                    end
                end
                F1_BRANCH_MAP: begin
                    p.payload = PL'(m_cnt) | (PL'(m_map) << 4) | (PL'(tc.pc) << 12);
                    p.len     = LW'(`TRDB_LEN_F1);
                end
                default: begin
                    p.payload = PL'(tc.pc);
                    p.len     = LW'(`TRDB_LEN_F2);
                end
            endcase
            // map is used up by F1 and by F3
            if (emit && p.ptype != F2_ADDR_ONLY) begin
                m_cnt = 0;
                m_map = '0;
            end
            if (emit) begin
                exp_q.push_back(p);
                refresh_head();
            end
        end
    endtask

    // strobe after gap idle cycles and move the program on to target
    task automatic retire_inst(input logic [31:0] inst, input logic en, input logic exc,
                               input int gap, input logic [31:0] target);
        trdb_inst_rec_t rec;
        repeat (gap) begin
            @(posedge clk_i);
            #1;
        end
        rec = '{exception: exc, interrupt: cur_intr, cause: cur_cause, priv: cur_priv,
                inst: inst, pc: pc_cur};
        exception_i    = rec.exception;
        interrupt_i    = rec.interrupt;
        cause_i        = rec.cause;
        priv_lvl_i     = rec.priv;
        inst_data_i    = rec.inst;
        pc_i           = rec.pc;
        trace_enable_i = en;
        inst_valid_i   = 1'b1;
        @(posedge clk_i);
        #1;
        inst_valid_i = 1'b0;
        m_rec[2] = m_rec[1];
        m_rec[1] = m_rec[0];
        m_rec[0] = rec;
        m_qual   = {m_qual[1:0], en};
        predict();
        pc_cur = target;
    endtask

    task automatic retire_nop(input logic en, input int gap);
        retire_inst(NOP, en, 1'b0, gap, pc_cur + 32'd4);
    endtask

    task automatic retire_branch(input logic taken, input int gap);
        retire_inst({25'($urandom), OPCODE_BRANCH}, 1'b1, 1'b0, gap,
                    taken ? pc_cur + 32'h40 : pc_cur + 32'd4);
    endtask

    task automatic retire_jump(input int gap);
        retire_inst({25'($urandom), OPCODE_JALR}, 1'b1, 1'b0, gap, $urandom & 32'hFFFF_FFFC);
    endtask

    task automatic finish_run(input logic timed_out);
        int proto_cnt;
        proto_cnt = DUT.u_asserts.fail_cnt;
        $display("errors: %0d value, %0d unexpected, %0d missing, %0d protocol",
                 err_cnt, unexp_cnt, miss_cnt, proto_cnt);
        if (!timed_out && err_cnt + unexp_cnt + miss_cnt + proto_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    // pulses are checked at the falling edge and the head moves on just after
    a_pkt_expected: assert property (@(negedge clk_i) disable iff (!rst_ni)
        packet_valid_o |-> head_avail)
        else begin
            unexp_cnt++;
            $display("unexpected packet at %0t, none was predicted", $time);
        end
    a_pkt_type: assert property (@(negedge clk_i) disable iff (!rst_ni)
        (packet_valid_o && head_avail) |-> packet_type_o == head.ptype)
        else begin
            err_cnt++;
            $display("Fail %0t packet_type_o got %0d expected %0d",
                     $time, packet_type_o, head.ptype);
        end
    a_pkt_sub: assert property (@(negedge clk_i) disable iff (!rst_ni)
        (packet_valid_o && head_avail && head.ptype == F3_SYNC)
        |-> packet_subformat_o == head.sub)
        else begin
            err_cnt++;
            $display("Fail %0t packet_subformat_o got %0d expected %0d",
                     $time, packet_subformat_o, head.sub);
        end
    a_pkt_len: assert property (@(negedge clk_i) disable iff (!rst_ni)
        (packet_valid_o && head_avail) |-> packet_length_o == head.len)
        else begin
            err_cnt++;
            $display("Fail %0t packet_length_o got %0d expected %0d",
                     $time, packet_length_o, head.len);
        end
    a_pkt_payload: assert property (@(negedge clk_i) disable iff (!rst_ni)
        (packet_valid_o && head_avail) |-> packet_payload_o == head.payload)
        else begin
            err_cnt++;
            $display("Fail %0t packet_payload_o got %h expected %h",
                     $time, packet_payload_o, head.payload);
        end

    always @(negedge clk_i) begin
        if (rst_ni && packet_valid_o) begin
            #1;
            if (exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
            refresh_head();
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the program did not finish", cycle_cnt);
        finish_run(1'b1);
    end

    initial begin
        void'($urandom(51006));
        rst_ni         = 1'b0;
        inst_valid_i   = 1'b0;
        exception_i    = 1'b0;
        interrupt_i    = 1'b0;
        cause_i        = '0;
        priv_lvl_i     = PRIV_LVL_M;
        inst_data_i    = '0;
        pc_i           = '0;
        trace_enable_i = 1'b0;
        m_rec          = '{default: '0};
        m_qual         = '0;
        m_cnt          = 0;
        m_map          = '0;
        err_cnt        = 0;
        unexp_cnt      = 0;
        miss_cnt       = 0;
        pc_cur         = 32'h8000_0000;
        cur_priv       = PRIV_LVL_M;
        cur_cause      = '0;
        cur_intr       = 1'b0;
        refresh_head();
        repeat (2) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        // no packets while trace is off
        repeat (4) retire_nop(1'b0, pick_gap());
        // first qualified instruction syncs and eight branches fill the map
        retire_nop(1'b1, pick_gap());
        repeat (8) retire_branch(1'($urandom), pick_gap());
        retire_nop(1'b1, pick_gap());
        // privilege change resyncs
        cur_priv = PRIV_LVL_S;
        retire_nop(1'b1, pick_gap());
        repeat (2) retire_branch(1'($urandom), pick_gap());
        // trap whose handler carries the held cause
        cur_cause = 5'($urandom);
        cur_intr  = 1'($urandom);
        retire_inst(NOP, 1'b1, 1'b1, pick_gap(), 32'h0000_1000);
        cur_priv = PRIV_LVL_M;
        retire_nop(1'b1, pick_gap());
        // jump with an empty map and then with pending branches
        retire_jump(pick_gap());
        retire_nop(1'b1, pick_gap());
        repeat (3) retire_branch(1'($urandom), pick_gap());
        retire_jump(pick_gap());
        retire_nop(1'b1, pick_gap());
        // back-to-back mix
        repeat (24) begin
            case ($urandom % 3)
                0: retire_nop(1'b1, 0);
                1: retire_branch(1'($urandom), 0);
                default: retire_jump(0);
            endcase
        end
        // last qualified branch closes the map when trace drops
        repeat (3) retire_branch(1'($urandom), 0);
        repeat (4) retire_nop(1'b0, 0);
        repeat (8) begin
            if (exp_q.size() != 0) begin
                @(posedge clk_i);
            end
        end
        repeat (3) @(posedge clk_i);
        if (exp_q.size() != 0) begin
            miss_cnt = exp_q.size();
            $display("%0d predicted packets never appeared", miss_cnt);
        end
        finish_run(1'b0);
    end

endmodule

`default_nettype wire

// ==== verification/trdb_asserts.sv ====
/*
 * protocol checks on the trace encoder packet port
 * bound into trace_debugger by the testbench
 */
`timescale 1ns/1ps
`default_nettype none

`include "trdb_config.svh"

module trdb_asserts (
    input logic                           clk_i,
    input logic                           rst_ni,
    input logic                           inst_valid_i,
    input logic                           packet_valid_o,
    input trdb_pkg::trdb_format_e         packet_type_o,
    input trdb_pkg::trdb_sync_subformat_e packet_subformat_o,
    input logic [`TRDB_PLEN_LEN-1:0]      packet_length_o
);

    import trdb_pkg::*;

    logic [1:0]                settle_cnt;
    logic [`TRDB_PLEN_LEN-1:0] len_exp;
    // failed checks so far
    int                        fail_cnt = 0;

    // rising edges since reset release up to 3
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            settle_cnt <= '0;
        end else if (settle_cnt != 2'd3) begin
            settle_cnt <= settle_cnt + 2'd1;
        end
    end

    // byte length each format must carry
    always_comb begin
        case (packet_type_o)
            F3_SYNC: len_exp = (packet_subformat_o == SF_TRAP) ?
                `TRDB_PLEN_LEN'(`TRDB_LEN_F3_TRAP) : `TRDB_PLEN_LEN'(`TRDB_LEN_F3_START);
            F1_BRANCH_MAP: len_exp = `TRDB_PLEN_LEN'(`TRDB_LEN_F1);
            default: len_exp = `TRDB_PLEN_LEN'(`TRDB_LEN_F2);
        endcase
    end

    // quiet in reset and for two cycles after it
    a_quiet_reset: assert property (@(negedge clk_i) (settle_cnt != 2'd3) |-> !packet_valid_o)
        else begin
            fail_cnt++;
            $error("packet_valid_o high during or right after reset");
        end

    a_length: assert property (@(negedge clk_i) disable iff (!rst_ni)
        packet_valid_o |-> packet_length_o == len_exp)
        else begin
            fail_cnt++;
            $error("packet_length_o does not fit packet_type_o and packet_subformat_o");
        end

    // a packet needs the strobe of the following instruction two edges earlier
    a_strobe_before: assert property (@(negedge clk_i) disable iff (!rst_ni)
        packet_valid_o |-> $past(inst_valid_i, 2))
        else begin
            fail_cnt++;
            $error("packet_valid_o without an instruction strobe two edges before");
        end

endmodule

`default_nettype wire

// ==== hw/trace_debugger.sv ====
/*
 * RISC-V instruction trace encoder
 * stages retired instructions as nc/tc/lc and emits sync, branch map
 * and address packets
 */
`timescale 1ns/1ps
`default_nettype none

`include "trdb_config.svh"

module trace_debugger (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           inst_valid_i,
    input  logic                           exception_i,
    input  logic                           interrupt_i,
    input  logic [`TRDB_CAUSE_LEN-1:0]     cause_i,
    input  trdb_rv_pkg::priv_lvl_e         priv_lvl_i,
    input  logic [`TRDB_INST_LEN-1:0]      inst_data_i,
    input  logic [`TRDB_PC_LEN-1:0]        pc_i,
    input  logic                           trace_enable_i,
    output logic                           packet_valid_o,
    output trdb_pkg::trdb_format_e         packet_type_o,
    output trdb_pkg::trdb_sync_subformat_e packet_subformat_o,
    output logic [`TRDB_PLEN_LEN-1:0]      packet_length_o,
    output logic [`TRDB_PAYLOAD_LEN-1:0]   packet_payload_o
);

    import trdb_pkg::*;

    // staged records and qualification
    trdb_inst_rec_t in_rec, nc_rec, tc_rec, lc_rec;
    logic           nc_qual, tc_qual, lc_qual;
    logic           tc_fresh;
    // tc classification
    logic           tc_branch, tc_taken, tc_updiscon;
    // branch map
    logic                        map_update;
    logic [`TRDB_BCOUNT_LEN-1:0] map_count;
    logic [`TRDB_BMAP_LEN-1:0]   map_bits;
    logic                        map_full, map_empty;
    // decision
    logic                        emit, flush;
    trdb_format_e                format;
    trdb_sync_subformat_e        subformat;

    // core signals of one retired instruction
    assign in_rec.exception = exception_i;
    assign in_rec.interrupt = interrupt_i;
    assign in_rec.cause     = cause_i;
    assign in_rec.priv      = priv_lvl_i;
    assign in_rec.inst      = inst_data_i;
    assign in_rec.pc        = pc_i;

    trdb_delay_line #(.T_DATA(trdb_inst_rec_t)) u_rec_line (
        .clk_i, .rst_ni,
        .shift_i(inst_valid_i), .data_i(in_rec),
        .nc_o(nc_rec), .tc_o(tc_rec), .lc_o(lc_rec), .tc_fresh_o(tc_fresh)
    );

    // enable level sampled with each instruction, fresh flag comes from the record line
    trdb_delay_line #(.T_DATA(logic)) u_qual_line (
        .clk_i, .rst_ni,
        .shift_i(inst_valid_i), .data_i(trace_enable_i),
        .nc_o(nc_qual), .tc_o(tc_qual), .lc_o(lc_qual), .tc_fresh_o()
    );

    trdb_itype_detector u_itype (
        .tc_inst_i(tc_rec.inst), .tc_pc_i(tc_rec.pc), .nc_pc_i(nc_rec.pc),
        .tc_branch_o(tc_branch), .tc_taken_o(tc_taken), .tc_updiscon_o(tc_updiscon)
    );

    // only qualified instructions touch the map
    assign map_update = tc_fresh && tc_qual;

    trdb_branch_map u_bmap (
        .clk_i, .rst_ni,
        .update_i(map_update), .branch_i(tc_branch), .taken_i(tc_taken), .flush_i(flush),
        .count_o(map_count), .map_o(map_bits), .full_o(map_full), .empty_o(map_empty)
    );

    trdb_priority u_priority (
        .clk_i, .rst_ni,
        .fresh_i(tc_fresh),
        .nc_qual_i(nc_qual), .tc_qual_i(tc_qual), .lc_qual_i(lc_qual),
        .lc_exception_i(lc_rec.exception),
        .tc_priv_i(tc_rec.priv), .lc_priv_i(lc_rec.priv),
        .tc_updiscon_i(tc_updiscon),
        .map_empty_i(map_empty), .map_full_i(map_full),
        .emit_o(emit), .format_o(format), .subformat_o(subformat), .flush_o(flush)
    );

    trdb_packet_emitter u_emitter (
        .clk_i, .rst_ni,
        .emit_i(emit), .format_i(format), .subformat_i(subformat),
        .tc_rec_i(tc_rec), .count_i(map_count), .map_i(map_bits),
        .packet_valid_o, .packet_type_o, .packet_subformat_o,
        .packet_length_o, .packet_payload_o
    );

endmodule

`default_nettype wire

// ==== hw/trdb_packet_emitter.sv ====
/*
 * packet emitter
 * packs the payload of the chosen format and registers the packet outputs
 */
`timescale 1ns/1ps
`default_nettype none

`include "trdb_config.svh"

module trdb_packet_emitter (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           emit_i,
    input  trdb_pkg::trdb_format_e         format_i,
    input  trdb_pkg::trdb_sync_subformat_e subformat_i,
    input  trdb_pkg::trdb_inst_rec_t       tc_rec_i,
    input  logic [`TRDB_BCOUNT_LEN-1:0]    count_i,
    input  logic [`TRDB_BMAP_LEN-1:0]      map_i,
    output logic                           packet_valid_o,
    output trdb_pkg::trdb_format_e         packet_type_o,
    output trdb_pkg::trdb_sync_subformat_e packet_subformat_o,
    output logic [`TRDB_PLEN_LEN-1:0]      packet_length_o,
    output logic [`TRDB_PAYLOAD_LEN-1:0]   packet_payload_o
);

    import trdb_pkg::*;

    logic [`TRDB_PAYLOAD_LEN-1:0] payload_d;
    logic [`TRDB_PLEN_LEN-1:0]    length_d;

    // fields LSB first, upper bits zero
    always_comb begin
        payload_d = '0;
        length_d  = `TRDB_PLEN_LEN'(`TRDB_LEN_F2);
        case (format_i)
            F3_SYNC: begin
                if (subformat_i == SF_TRAP) begin
                    payload_d = `TRDB_PAYLOAD_LEN'({tc_rec_i.pc, tc_rec_i.interrupt,
                                                    tc_rec_i.cause, tc_rec_i.priv,
                                                    subformat_i});
                    length_d  = `TRDB_PLEN_LEN'(`TRDB_LEN_F3_TRAP);
                end else begin
                    payload_d = `TRDB_PAYLOAD_LEN'({tc_rec_i.pc, tc_rec_i.priv,
                                                    subformat_i});
                    length_d  = `TRDB_PLEN_LEN'(`TRDB_LEN_F3_START);
                end
            end
            F1_BRANCH_MAP: begin
                payload_d = `TRDB_PAYLOAD_LEN'({tc_rec_i.pc, map_i, count_i});
                length_d  = `TRDB_PLEN_LEN'(`TRDB_LEN_F1);
            end
            default: begin
                // address only
                payload_d = `TRDB_PAYLOAD_LEN'(tc_rec_i.pc);
            end
        endcase
    end

    // single-cycle strobe, no back-pressure
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            packet_valid_o <= 1'b0;
        end else begin
            packet_valid_o <= emit_i;
        end
    end

    // packet fields only load with a packet
    always_ff @(posedge clk_i) begin
        if (emit_i) begin
            packet_type_o      <= format_i;
            packet_subformat_o <= subformat_i;
            packet_length_o    <= length_d;
            packet_payload_o   <= payload_d;
        end
    end

endmodule

`default_nettype wire

// ==== hw/trdb_priority.sv ====
/*
 * packet priority
 * picks the packet format for a fresh tc from the nc/tc/lc state
 */
`timescale 1ns/1ps
`default_nettype none

module trdb_priority (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           fresh_i,
    input  logic                           nc_qual_i,
    input  logic                           tc_qual_i,
    input  logic                           lc_qual_i,
    input  logic                           lc_exception_i,
    input  trdb_rv_pkg::priv_lvl_e         tc_priv_i,
    input  trdb_rv_pkg::priv_lvl_e         lc_priv_i,
    input  logic                           tc_updiscon_i,
    input  logic                           map_empty_i,
    input  logic                           map_full_i,
    output logic                           emit_o,
    output trdb_pkg::trdb_format_e         format_o,
    output trdb_pkg::trdb_sync_subformat_e subformat_o,
    output logic                           flush_o
);

    import trdb_pkg::*;

    // tc updiscon becomes lc updiscon on the next instruction
    logic lc_updiscon_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lc_updiscon_q <= 1'b0;
        end else if (fresh_i) begin
            lc_updiscon_q <= tc_updiscon_i;
        end
    end

    // first match wins
    always_comb begin
        emit_o      = 1'b0;
        format_o    = F2_ADDR_ONLY;
        subformat_o = SF_START;
        if (fresh_i && tc_qual_i) begin
            if (!lc_qual_i) begin
                // first qualified instruction
                emit_o   = 1'b1;
                format_o = F3_SYNC;
            end else if (lc_exception_i) begin
                // tc is the trap handler entry
                emit_o      = 1'b1;
                format_o    = F3_SYNC;
                subformat_o = SF_TRAP;
            end else if (tc_priv_i != lc_priv_i) begin
                emit_o   = 1'b1;
                format_o = F3_SYNC;
            end else if (lc_updiscon_q || !nc_qual_i) begin
                // jump target, or last qualified instruction
                emit_o   = 1'b1;
                format_o = map_empty_i ? F2_ADDR_ONLY : F1_BRANCH_MAP;
            end else if (map_full_i) begin
                emit_o   = 1'b1;
                format_o = F1_BRANCH_MAP;
            end
        end
    end

    // F1 and F3 both consume the map
    assign flush_o = emit_o && (format_o != F2_ADDR_ONLY);

endmodule

`default_nettype wire

// ==== hw/trdb_branch_map.sv ====
/*
 * branch map
 * collects one not-taken bit per qualified branch until a packet flushes it
 */
`timescale 1ns/1ps
`default_nettype none

`include "trdb_config.svh"

module trdb_branch_map (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        update_i,
    input  logic                        branch_i,
    input  logic                        taken_i,
    input  logic                        flush_i,
    output logic [`TRDB_BCOUNT_LEN-1:0] count_o,
    output logic [`TRDB_BMAP_LEN-1:0]   map_o,
    output logic                        full_o,
    output logic                        empty_o
);

    logic [`TRDB_BCOUNT_LEN-1:0] count_q;
    logic [`TRDB_BCOUNT_LEN-1:0] count_d;
    logic [`TRDB_BMAP_LEN-1:0]   map_q;
    logic [`TRDB_BMAP_LEN-1:0]   map_d;
    logic                        pend;

    // tc branch waiting to enter the map
    assign pend = update_i && branch_i;

    // map as the packet would carry it, tc bit included
    always_comb begin
        count_d = count_q;
        map_d   = map_q;
        if (pend) begin
            count_d = count_q + `TRDB_BCOUNT_LEN'(1);
            // 1 marks a not-taken branch
            map_d   = map_q | (`TRDB_BMAP_LEN'(!taken_i) << count_q);
        end
    end

    assign count_o = count_d;
    assign map_o   = map_d;
    assign full_o  = (count_d == `TRDB_BCOUNT_LEN'(`TRDB_BMAP_LEN));
    assign empty_o = (count_d == '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
            map_q   <= '0;
        end else if (flush_i) begin
            // bits went out with an F1, or an F3 resynced the decoder
            count_q <= '0;
            map_q   <= '0;
        end else begin
            count_q <= count_d;
            map_q   <= map_d;
        end
    end

endmodule

`default_nettype wire

// ==== hw/trdb_itype_detector.sv ====
/*
 * instruction type detector
 * flags the tc instruction as branch, taken branch or uninferable jump
 */
`timescale 1ns/1ps
`default_nettype none

`include "trdb_config.svh"

module trdb_itype_detector (
    input  logic [`TRDB_INST_LEN-1:0] tc_inst_i,
    input  logic [`TRDB_PC_LEN-1:0]   tc_pc_i,
    input  logic [`TRDB_PC_LEN-1:0]   nc_pc_i,
    output logic                      tc_branch_o,
    output logic                      tc_taken_o,
    output logic                      tc_updiscon_o
);

    import trdb_rv_pkg::*;

    opcode_e                  opcode;
    logic [`TRDB_PC_LEN-1:0]  seq_pc;

    // major opcode sits in the low 7 bits
    assign opcode = opcode_e'(tc_inst_i[6:0]);

    // no compressed support, so the next sequential pc is always +4
    assign seq_pc = tc_pc_i + `TRDB_PC_LEN'(4);

    // conditional branches
    assign tc_branch_o = (opcode == OPCODE_BRANCH);

    // taken when the next retired pc is not the fall-through one
    assign tc_taken_o = tc_branch_o && (nc_pc_i != seq_pc);

    // jalr target cannot be inferred by the decoder
    assign tc_updiscon_o = (opcode == OPCODE_JALR);

endmodule

`default_nettype wire

// ==== hw/trdb_delay_line.sv ====
/*
 * nc/tc/lc delay line
 * three register stages for any payload, shifted once per retired instruction
 */
`timescale 1ns/1ps
`default_nettype none

module trdb_delay_line #(
    parameter type T_DATA = logic
) (
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  shift_i,
    input  T_DATA data_i,
    output T_DATA nc_o,
    output T_DATA tc_o,
    output T_DATA lc_o,
    output logic  tc_fresh_o
);

    T_DATA nc_q;
    T_DATA tc_q;
    T_DATA lc_q;
    logic  fresh_q;

    // taps are zero after reset so nothing looks qualified
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            nc_q    <= '0;
            tc_q    <= '0;
            lc_q    <= '0;
            fresh_q <= 1'b0;
        end else begin
            // one pulse per shift, marks a new tc
            fresh_q <= shift_i;
            if (shift_i) begin
                nc_q <= data_i;
                tc_q <= nc_q;
                lc_q <= tc_q;
            end
        end
    end

    assign nc_o       = nc_q;
    assign tc_o       = tc_q;
    assign lc_o       = lc_q;
    assign tc_fresh_o = fresh_q;

endmodule

`default_nettype wire

// ==== common/trdb_pkg.sv ====
/*
 * trace encoder types
 * packet formats, sync subformats and the retired instruction record
 */
`default_nettype none

`include "trdb_config.svh"

package trdb_pkg;

    // packet format, as carried on packet_type_o
    typedef enum logic [1:0] {
        F1_BRANCH_MAP = 2'd1,
        F2_ADDR_ONLY  = 2'd2,
        F3_SYNC       = 2'd3
    } trdb_format_e;

    // subformat of a sync packet
    typedef enum logic [1:0] {
        SF_START = 2'd0,
        SF_TRAP  = 2'd1
    } trdb_sync_subformat_e;

    // one retired instruction, as staged through nc/tc/lc
    typedef struct packed {
        logic                        exception;
        // tells an interrupt from an exception
        logic                        interrupt;
        logic [`TRDB_CAUSE_LEN-1:0]  cause;
        trdb_rv_pkg::priv_lvl_e      priv;
        logic [`TRDB_INST_LEN-1:0]   inst;
        logic [`TRDB_PC_LEN-1:0]     pc;
    } trdb_inst_rec_t;

endpackage

`default_nettype wire

// ==== common/trdb_rv_pkg.sv ====
/*
 * RISC-V encodings the trace encoder decodes
 * major opcodes and privilege levels
 */
`default_nettype none

package trdb_rv_pkg;

    // major opcode, bits 6:0 of the instruction word
    typedef enum logic [6:0] {
        OPCODE_BRANCH = 7'b1100011,
        // indirect jump, target not inferable from the binary
        OPCODE_JALR   = 7'b1100111
    } opcode_e;

    // privilege level as reported by the core
    typedef enum logic [1:0] {
        PRIV_LVL_U = 2'b00,
        PRIV_LVL_S = 2'b01,
        PRIV_LVL_M = 2'b11
    } priv_lvl_e;

endpackage

`default_nettype wire

// ==== common/trdb_config.svh ====
/*
 * trace encoder configuration
 * field widths, branch map size and payload length of each packet format
 */
`ifndef TRDB_CONFIG_SVH
`define TRDB_CONFIG_SVH

// instruction record fields
`define TRDB_PC_LEN       32
`define TRDB_CAUSE_LEN    5
`define TRDB_INST_LEN     32

// branch map, count must hold BMAP_LEN itself
`define TRDB_BMAP_LEN     8
`define TRDB_BCOUNT_LEN   4

// packet payload and its length field in bytes
`define TRDB_PAYLOAD_LEN  48
`define TRDB_PLEN_LEN     3

// payload length per format, in bytes
`define TRDB_LEN_F3_START 5
`define TRDB_LEN_F3_TRAP  6
`define TRDB_LEN_F2       4
`define TRDB_LEN_F1       6

`endif
